// ==== source/limiter_cfg.svh ====
// limiter build constants, include in every rtl file before the packages are used
`ifndef LIMITER_CFG_SVH
`define LIMITER_CFG_SVH

// ----------------------------------------------------------------------
// packet field widths
// ----------------------------------------------------------------------

// destination id carried in every command beat, 8 slaves max
`define LIM_DEST_ID_W 3

// data field shared by command and response packets
`define LIM_DATA_W 32

// ----------------------------------------------------------------------
// outstanding response tracking
// ----------------------------------------------------------------------

// non-posted packets allowed in flight before the limiter backpressures
`define LIM_MAX_OUTSTANDING 4

// must hold 0 .. LIM_MAX_OUTSTANDING inclusive
`define LIM_COUNT_W 3

`endif

// ==== source/limiter_pkt_pkg.sv ====
// packet and stream beat types seen on the limiter's command and response ports
`include "limiter_cfg.svh"

package limiter_pkt_pkg;

   // ----------------------------------------------------------------------
   // command side
   // ----------------------------------------------------------------------

   // one command packet word
   // posted set means no response comes back for this packet
   typedef struct packed {
      logic [`LIM_DEST_ID_W-1:0] dest_id;
      logic                      posted;
      logic [`LIM_DATA_W-1:0]    data;
   } cmd_pkt_t;

   // command beat with packet framing
   typedef struct packed {
      cmd_pkt_t pkt;
      logic     sop;
      logic     eop;
   } cmd_beat_t;

   // ----------------------------------------------------------------------
   // response side
   // ----------------------------------------------------------------------

   // response beat, src_id names the slave that answered
   typedef struct packed {
      logic [`LIM_DEST_ID_W-1:0] src_id;
      logic [`LIM_DATA_W-1:0]    data;
      logic                      sop;
      logic                      eop;
   } rsp_beat_t;

endpackage

// ==== source/limiter_ctrl_pkg.sv ====
// internal control types of the limiter, shared by the input stage and the order guard
`include "limiter_cfg.svh"

package limiter_ctrl_pkg;

   // ----------------------------------------------------------------------
   // response accounting
   // ----------------------------------------------------------------------

   // number of non-posted packets still waiting for their response eop
   typedef logic [`LIM_COUNT_W-1:0] pend_count_t;

   // ----------------------------------------------------------------------
   // command stage payload
   // ----------------------------------------------------------------------

   // command beat as held in the pipeline stage
   // dest_changed compares against the last accepted non-posted destination
   typedef struct packed {
      limiter_pkt_pkg::cmd_beat_t beat;
      logic                       dest_changed;
   } staged_cmd_t;

endpackage

// ==== source/cmd_input_stage.sv ====
// command input stage: tags beats with a destination change flag and buffers them two deep
`timescale 1ns/10ps
`include "limiter_cfg.svh"

module cmd_input_stage (
   input  logic                         clk,
   input  logic                         reset,
   // command sink from the master
   input  logic                         cmd_sink_valid,
   input  limiter_pkt_pkg::cmd_beat_t   cmd_sink_beat,
   output logic                         cmd_sink_ready,
   // staged stream towards the order guard
   output logic                         stage_valid,
   output limiter_ctrl_pkg::staged_cmd_t stage_cmd,
   input  logic                         stage_ready
);

   import limiter_ctrl_pkg::*;

   // ----------------------------------------------------------------------
   // destination tracking
   // ----------------------------------------------------------------------
   logic [`LIM_DEST_ID_W-1:0] last_dest_id;
   staged_cmd_t               tagged_cmd;
   logic                      push;
   logic                      pop;

   assign push = cmd_sink_valid & cmd_sink_ready;
   assign pop  = stage_valid & stage_ready;

   // tag against the last non-posted destination accepted here
   // later beats of the same packet compare equal once sop has updated it
   always_comb begin
      tagged_cmd.beat         = cmd_sink_beat;
      tagged_cmd.dest_changed = (cmd_sink_beat.pkt.dest_id != last_dest_id);
   end

   // only non-posted traffic produces responses, so only it moves the tracker
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         last_dest_id <= '0;
      end else if (push && !cmd_sink_beat.pkt.posted) begin
         last_dest_id <= cmd_sink_beat.pkt.dest_id;
      end
   end

   // ----------------------------------------------------------------------
   // two entry stage
   // ----------------------------------------------------------------------
   // entry0 is the head and drives the output
   // entry1 catches the beat that arrives while the head is stalled
   staged_cmd_t entry0;
   staged_cmd_t entry1;
   logic [1:0]  fill;
   logic [1:0]  fill_next;

   always_comb begin
      fill_next = fill;
      if (push && !pop) begin
         fill_next = fill + 2'd1;
      end else if (pop && !push) begin
         fill_next = fill - 2'd1;
      end
   end

   // occupancy and registered ready
   // ready low out of reset, then high whenever a slot will be free
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         fill           <= 2'd0;
         cmd_sink_ready <= 1'b0;
      end else begin
         fill           <= fill_next;
         cmd_sink_ready <= (fill_next != 2'd2);
      end
   end

   // payload moves, no reset needed on data
   always_ff @(posedge clk) begin
      if (pop) begin
         // head leaves; refill from skid slot or straight from sink
         if (fill == 2'd2) begin
            entry0 <= entry1;
         end else if (push) begin
            entry0 <= tagged_cmd;
         end
      end else if (push) begin
         if (fill == 2'd0) begin
            entry0 <= tagged_cmd;
         end else begin
            entry1 <= tagged_cmd;
         end
      end
   end

   assign stage_valid = (fill != 2'd0);
   assign stage_cmd   = entry0;

endmodule

// ==== source/order_guard.sv ====
// order guard: counts pending non-posted packets and holds back commands that would reorder
`timescale 1ns/10ps
`include "limiter_cfg.svh"

module order_guard (
   input  logic                          clk,
   input  logic                          reset,
   // staged stream from the input stage
   input  logic                          stage_valid,
   input  limiter_ctrl_pkg::staged_cmd_t stage_cmd,
   output logic                          stage_ready,
   // command source towards the network
   output logic                          cmd_src_valid,
   output limiter_pkt_pkg::cmd_beat_t    cmd_src_beat,
   input  logic                          cmd_src_ready,
   // response eop accepted at the response sink
   input  logic                          rsp_done
);

   import limiter_ctrl_pkg::*;

   // ----------------------------------------------------------------------
   // pending response counter
   // ----------------------------------------------------------------------
   pend_count_t pend_count;
   pend_count_t count_next;
   logic        has_pending;
   logic        count_max_reached;
   logic        nonposted;
   logic        np_eop_sent;
   logic        suppress;

   assign nonposted = ~stage_cmd.beat.pkt.posted;

   // a non-posted packet counts once, on its last beat leaving
   assign np_eop_sent = nonposted & cmd_src_valid & cmd_src_ready & stage_cmd.beat.eop;

   // send and response in the same cycle cancel out
   always_comb begin
      count_next = pend_count;
      if (np_eop_sent && !rsp_done) begin
         count_next = pend_count + 1'b1;
      end else if (rsp_done && !np_eop_sent) begin
         count_next = pend_count - 1'b1;
      end
   end

   // flags are registered from the next count so they track pend_count exactly
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         pend_count        <= '0;
         has_pending       <= 1'b0;
         count_max_reached <= 1'b0;
      end else begin
         pend_count        <= count_next;
         has_pending       <= (count_next != '0);
         count_max_reached <= (count_next == pend_count_t'(`LIM_MAX_OUTSTANDING));
      end
   end

   // ----------------------------------------------------------------------
   // suppression
   // ----------------------------------------------------------------------
   // switching slaves with responses in flight could let the new slave
   // answer first, so the beat waits until the counter drains
   // at the limit every non-posted beat waits, whatever its destination
   // posted beats never wait
   assign suppress = nonposted &
                     ((has_pending & stage_cmd.dest_changed) | count_max_reached);

   // a suppressed beat is hidden from both sides of the handshake
   // it stays in the stage and keeps the input stage from advancing
   always_comb begin
      cmd_src_valid = stage_valid;
      stage_ready   = cmd_src_ready;
      if (suppress) begin
         cmd_src_valid = 1'b0;
         stage_ready   = 1'b0;
      end
   end

   // tag is internal, the network sees the plain beat
   assign cmd_src_beat = stage_cmd.beat;

endmodule

// ==== source/traffic_limiter.sv ====
// traffic limiter top: command stage plus order guard, responses pass straight through
`timescale 1ns/10ps
`include "limiter_cfg.svh"

module traffic_limiter (
   input  logic                       clk,
   input  logic                       reset,
   // ----------------------------------------------------------------------
   // command path
   // ----------------------------------------------------------------------
   input  logic                       cmd_sink_valid,
   input  limiter_pkt_pkg::cmd_beat_t cmd_sink_beat,
   output logic                       cmd_sink_ready,
   output logic                       cmd_src_valid,
   output limiter_pkt_pkg::cmd_beat_t cmd_src_beat,
   input  logic                       cmd_src_ready,
   // ----------------------------------------------------------------------
   // response path
   // ----------------------------------------------------------------------
   input  logic                       rsp_sink_valid,
   input  limiter_pkt_pkg::rsp_beat_t rsp_sink_beat,
   output logic                       rsp_sink_ready,
   output logic                       rsp_src_valid,
   output limiter_pkt_pkg::rsp_beat_t rsp_src_beat,
   input  logic                       rsp_src_ready
);

   import limiter_ctrl_pkg::*;

   // staged stream between the two command blocks
   logic        stage_valid;
   logic        stage_ready;
   staged_cmd_t stage_cmd;
   logic        rsp_done;

   // one registered stage, tags destination changes
   cmd_input_stage cmd_input_stage_inst (
      .clk            (clk),
      .reset          (reset),
      .cmd_sink_valid (cmd_sink_valid),
      .cmd_sink_beat  (cmd_sink_beat),
      .cmd_sink_ready (cmd_sink_ready),
      .stage_valid    (stage_valid),
      .stage_cmd      (stage_cmd),
      .stage_ready    (stage_ready)
   );

   // counts outstanding packets and gates the source handshake
   order_guard order_guard_inst (
      .clk           (clk),
      .reset         (reset),
      .stage_valid   (stage_valid),
      .stage_cmd     (stage_cmd),
      .stage_ready   (stage_ready),
      .cmd_src_valid (cmd_src_valid),
      .cmd_src_beat  (cmd_src_beat),
      .cmd_src_ready (cmd_src_ready),
      .rsp_done      (rsp_done)
   );

   // responses are never reordered here, zero latency pass through
   assign rsp_src_valid  = rsp_sink_valid;
   assign rsp_src_beat   = rsp_sink_beat;
   assign rsp_sink_ready = rsp_src_ready;

   // one response packet retired per accepted eop
   assign rsp_done = rsp_sink_valid & rsp_sink_ready & rsp_sink_beat.eop;

endmodule

// ==== verification/traffic_limiter_sva.sv ====
// protocol assertions for the traffic limiter, attached to every instance with bind
`timescale 1ns/10ps
`include "limiter_cfg.svh"

module traffic_limiter_sva (
   input logic                       clk,
   input logic                       reset,
   input logic                       cmd_src_valid,
   input limiter_pkt_pkg::cmd_beat_t cmd_src_beat,
   input logic                       cmd_src_ready,
   input logic                       rsp_sink_valid,
   input limiter_pkt_pkg::rsp_beat_t rsp_sink_beat,
   input logic                       rsp_sink_ready
);

   import limiter_pkt_pkg::*;

   // ----------------------------------------------------------------------
   // local count of non-posted packets in flight
   // ----------------------------------------------------------------------
   logic [7:0] model_count;
   logic       np_sent;
   logic       rsp_seen;

   assign np_sent  = cmd_src_valid & cmd_src_ready & cmd_src_beat.eop & ~cmd_src_beat.pkt.posted;
   assign rsp_seen = rsp_sink_valid & rsp_sink_ready & rsp_sink_beat.eop;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         model_count <= 8'd0;
      end else if (np_sent && !rsp_seen) begin
         model_count <= model_count + 8'd1;
      end else if (rsp_seen && !np_sent) begin
         model_count <= model_count - 8'd1;
      end
   end

   // ----------------------------------------------------------------------
   // properties
   // ----------------------------------------------------------------------
   // held beat must not change or vanish while the network stalls
   assert property (@(posedge clk) disable iff (reset)
      (cmd_src_valid && !cmd_src_ready) |=> (cmd_src_valid && $stable(cmd_src_beat)))
      else $error("cmd_src beat changed or dropped under back-pressure");

   // a response eop with nothing in flight means the count is broken
   assert property (@(posedge clk) disable iff (reset)
      rsp_seen |-> (model_count != 8'd0))
      else $error("response eop accepted with no non-posted packet pending");

   assert property (@(posedge clk) reset |-> !cmd_src_valid)
      else $error("cmd_src_valid high during reset");

endmodule

bind traffic_limiter traffic_limiter_sva traffic_limiter_sva_inst (.*);

// ==== verification/traffic_limiter_tb.sv ====
// testbench for the traffic limiter: scripted and random traffic, checks by assertions
`timescale 1ns/10ps
`include "limiter_cfg.svh"

module traffic_limiter_tb;

   import limiter_pkt_pkg::*;

   logic clk, reset, reset_d;
   logic cmd_sink_valid, cmd_sink_ready, cmd_src_valid, cmd_src_ready;
   cmd_beat_t cmd_sink_beat, cmd_src_beat;
   logic rsp_sink_valid, rsp_sink_ready, rsp_src_valid, rsp_src_ready;
   rsp_beat_t rsp_sink_beat, rsp_src_beat;

   // ----------------------------------------------------------------------
   // model state, all updated on the rising edge
   // ----------------------------------------------------------------------
   cmd_beat_t exp_q[$];
   cmd_beat_t exp_head;
   logic exp_empty;
   logic [7:0] model_count;
   logic [`LIM_DEST_ID_W-1:0] model_last_dest;
   logic [31:0] sent_np, started_rsp, cycles, seed, rnd;
   logic cmd_acc, rsp_hold;
   integer errors;

   traffic_limiter traffic_limiter_inst (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic report_failure(input string msg);
      errors = errors + 1;
      $display("%s", msg);
      $display("Errors found");
      $fatal(1);
   endtask

   always @(posedge clk) begin
      reset_d <= reset;
      cmd_acc <= cmd_sink_valid & cmd_sink_ready;
      cycles  <= cycles + 32'd1;
      if (cycles >= 32'd4000) begin
         report_failure("Timeout: the run did not finish within 4000 cycles");
      end
      if (cmd_src_valid && cmd_src_ready && exp_q.size() != 0) begin
         void'(exp_q.pop_front());
         if (cmd_src_beat.eop && !cmd_src_beat.pkt.posted) begin
            sent_np = sent_np + 32'd1;
            model_count = model_count + 8'd1;
         end
         if (!cmd_src_beat.pkt.posted) begin
            model_last_dest = cmd_src_beat.pkt.dest_id;
         end
      end
      if (rsp_sink_valid && rsp_src_ready && rsp_sink_beat.eop) begin
         model_count = model_count - 8'd1;
      end
      if (cmd_sink_valid && cmd_sink_ready) begin
         exp_q.push_back(cmd_sink_beat);
      end
      exp_empty = (exp_q.size() == 0);
      exp_head  = exp_empty ? '0 : exp_q[0];
   end

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------
   // 1: commands leave in order, none lost or duplicated
   assert property (@(posedge clk) disable iff (reset)
      (cmd_src_valid && cmd_src_ready) |-> (!exp_empty && cmd_src_beat == exp_head))
      else report_failure($sformatf("Error at %0t: cmd_src_beat expected %h actual %h",
         $time, $sampled(exp_head), $sampled(cmd_src_beat)));
   // 2: destination switch only with nothing pending
   assert property (@(posedge clk) disable iff (reset)
      (cmd_src_valid && cmd_src_ready && !cmd_src_beat.pkt.posted &&
       cmd_src_beat.pkt.dest_id != model_last_dest) |-> (model_count == 8'd0))
      else report_failure($sformatf("Error at %0t: model_count expected 0 actual %0d",
         $time, $sampled(model_count)));
   // 3: outstanding limit
   assert property (@(posedge clk) disable iff (reset)
      model_count <= 8'(`LIM_MAX_OUTSTANDING))
      else report_failure($sformatf("Error at %0t: model_count expected <= %0d actual %0d",
         $time, `LIM_MAX_OUTSTANDING, $sampled(model_count)));
   assert property (@(posedge clk) disable iff (reset)
      (model_count == 8'(`LIM_MAX_OUTSTANDING) && traffic_limiter_inst.stage_valid &&
       !traffic_limiter_inst.stage_cmd.beat.pkt.posted) |-> !cmd_src_valid)
      else report_failure($sformatf("Error at %0t: cmd_src_valid expected 0 actual 1", $time));
   // 4: DUT count follows the model, so posted packets never raise it
   assert property (@(posedge clk) disable iff (reset)
      8'(traffic_limiter_inst.order_guard_inst.pend_count) == model_count)
      else report_failure($sformatf("Error at %0t: pend_count expected %0d actual %0d",
         $time, $sampled(model_count),
         $sampled(traffic_limiter_inst.order_guard_inst.pend_count)));
   // 4: posted beats are never held back, even toward a new slave with responses owed
   assert property (@(posedge clk) disable iff (reset)
      (traffic_limiter_inst.stage_valid && traffic_limiter_inst.stage_cmd.beat.pkt.posted)
      |-> cmd_src_valid)
      else report_failure($sformatf("Error at %0t: cmd_src_valid expected 1 actual 0", $time));
   // 5: response pass through
   assert property (@(posedge clk) rsp_src_valid == rsp_sink_valid)
      else report_failure($sformatf("Error at %0t: rsp_src_valid expected %b actual %b",
         $time, $sampled(rsp_sink_valid), $sampled(rsp_src_valid)));
   assert property (@(posedge clk) rsp_sink_ready == rsp_src_ready)
      else report_failure($sformatf("Error at %0t: rsp_sink_ready expected %b actual %b",
         $time, $sampled(rsp_src_ready), $sampled(rsp_sink_ready)));
   assert property (@(posedge clk) rsp_src_beat == rsp_sink_beat)
      else report_failure($sformatf("Error at %0t: rsp_src_beat expected %h actual %h",
         $time, $sampled(rsp_sink_beat), $sampled(rsp_src_beat)));
   // 6: quiet during reset and on the first edge after it
   assert property (@(posedge clk) (reset || reset_d) |-> (!cmd_src_valid && !cmd_sink_ready))
      else report_failure($sformatf(
         "Error at %0t: cmd_src_valid/cmd_sink_ready expected 0/0 actual %b/%b",
         $time, $sampled(cmd_src_valid), $sampled(cmd_sink_ready)));

   // ----------------------------------------------------------------------
   // network side, responses and ready stalls
   // ----------------------------------------------------------------------
   initial begin : network_driver
      logic [1:0] beats_left;
      rsp_sink_valid = 1'b0;
      rsp_sink_beat  = '0;
      rsp_src_ready  = 1'b0;
      cmd_src_ready  = 1'b0;
      started_rsp    = 32'd0;
      beats_left     = 2'd0;
      forever begin
         @(negedge clk);
         // ready was unchanged since the edge, so this beat transferred
         if (rsp_sink_valid && rsp_src_ready) begin
            if (rsp_sink_beat.eop) begin
               rsp_sink_valid = 1'b0;
            end else begin
               beats_left = beats_left - 2'd1;
               rsp_sink_beat.sop = 1'b0;
               rsp_sink_beat.eop = (beats_left == 2'd1);
               rsp_sink_beat.data = $random(seed);
            end
         end
         rnd = $random(seed);
         if (!rsp_sink_valid && !rsp_hold && sent_np != started_rsp && rnd[1:0] == 2'd0) begin
            started_rsp        = started_rsp + 32'd1;
            beats_left         = rnd[4] ? 2'd2 : 2'd1;
            rsp_sink_beat.src_id = rnd[10:8];
            rsp_sink_beat.data = $random(seed);
            rsp_sink_beat.sop  = 1'b1;
            rsp_sink_beat.eop  = (beats_left == 2'd1);
            rsp_sink_valid     = 1'b1;
         end
         rsp_src_ready = (rnd[3:2] != 2'd0);
         cmd_src_ready = (rnd[6:5] != 2'd0);
      end
   end

   // one packet, every beat held until accepted
   task automatic send_packet(input logic [2:0] dest, input logic posted, input int len);
      for (int i = 0; i < len; i++) begin
         cmd_sink_beat.pkt.dest_id = dest;
         cmd_sink_beat.pkt.posted  = posted;
         cmd_sink_beat.pkt.data    = $random(seed);
         cmd_sink_beat.sop         = (i == 0);
         cmd_sink_beat.eop         = (i == len - 1);
         cmd_sink_valid            = 1'b1;
         do @(negedge clk); while (!cmd_acc);
      end
      cmd_sink_valid = 1'b0;
   endtask

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------
   initial begin
      logic [31:0] pick;
      seed = 32'ha86f;
      errors = 0;
      cycles = 32'd0;
      sent_np = 32'd0;
      model_count = 8'd0;
      model_last_dest = '0;
      exp_empty = 1'b1;
      exp_head = '0;
      rsp_hold = 1'b1;
      cmd_sink_valid = 1'b0;
      cmd_sink_beat = '0;
      reset = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      // posted packet to a new slave while a response is owed
      send_packet(3'd1, 1'b0, 2);
      send_packet(3'd6, 1'b1, 2);
      send_packet(3'd1, 1'b0, 1);
      // switch of slave waits for the drain
      rsp_hold = 1'b0;
      send_packet(3'd2, 1'b0, 1);
      while (exp_q.size() != 0) @(negedge clk);
      // fill up to the limit with responses held back
      rsp_hold = 1'b1;
      for (int i = 0; i < 5; i++) begin
         send_packet(3'd2, 1'b0, 1);
      end
      repeat (10) @(negedge clk);
      rsp_hold = 1'b0;
      for (int i = 0; i < 250; i++) begin
         pick = $random(seed);
         send_packet(pick[2:0], pick[3], (pick[5:4] == 2'd0) ? 1 : int'(pick[5:4]));
         repeat (int'(pick[7:6] == 2'd3)) @(negedge clk);
      end
      while (exp_q.size() != 0 || model_count != 8'd0) @(negedge clk);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+source
source/limiter_pkt_pkg.sv
source/limiter_ctrl_pkg.sv
source/cmd_input_stage.sv
source/order_guard.sv
source/traffic_limiter.sv
verification/traffic_limiter_sva.sv
verification/traffic_limiter_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the traffic limiter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f \
   --top-module traffic_limiter_tb -o sim_tb > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

grep -q "^No errors$" sim.log && echo "PASS" \
   || { echo "FAIL"; exit 1; }
